// ==== Bender.yml ====
package:
  name: core_top

sources:
  - hw/core_pkg.sv
  - hw/memory.sv
  - hw/arith_unit.sv
  - hw/address_regs.sv
  - hw/pulse_unit.sv
  - hw/core_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/core_top_tb.sv

// ==== hw/address_regs.sv ====
`timescale 1ns/100ps

module address_regs (
    input  logic                        clk,
    input  logic                        arst_n,
    input  core_pkg::addr_op_e          addr_op,
    input  logic [core_pkg::ADDR_W-1:0] pnl_arr_strt_value,
    input  logic [core_pkg::ADDR_W-1:0] pnl_arr_sel_value,
    input  logic [core_pkg::WORD_W-1:0] wb_dat_r,
    output logic [core_pkg::ADDR_W-1:0] strt_value,
    output logic [core_pkg::ADDR_W-1:0] sel_value
);

    logic [core_pkg::ADDR_W-1:0] addr1;
    logic [core_pkg::ADDR_W-1:0] addr2;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            strt_value <= '0;
            sel_value  <= '0;
            addr1      <= '0;
            addr2      <= '0;
        end else begin
            case (addr_op)
                core_pkg::ADDR_ARR_STRT: strt_value <= pnl_arr_strt_value;
                core_pkg::ADDR_ARR_SEL:  sel_value  <= pnl_arr_sel_value;
                core_pkg::ADDR_LOAD_INSTR: begin
                    addr1      <= wb_dat_r[core_pkg::ADDR1_LSB +: core_pkg::ADDR_W];
                    addr2      <= wb_dat_r[core_pkg::ADDR_W-1:0];
                    strt_value <= strt_value + 1'b1;  // wraps at 12 bits
                end
                core_pkg::ADDR_SEL_STRT:  sel_value <= strt_value;
                core_pkg::ADDR_SEL_ADDR1: sel_value <= addr1;
                core_pkg::ADDR_SEL_ADDR2: sel_value <= addr2;
                core_pkg::ADDR_JUMP: begin
                    strt_value <= addr1;
                    sel_value  <= addr1;  // lets a fetch follow at once
                end
                default: ;  // no command
            endcase
        end
    end

endmodule

// ==== hw/arith_unit.sv ====
`timescale 1ns/100ps

module arith_unit (
    input  logic                        clk,
    input  logic                        arst_n,
    input  core_pkg::alu_op_e           alu_op,
    input  logic [core_pkg::WORD_W-1:0] pnl_arr_reg_c_value,
    input  logic [core_pkg::WORD_W-1:0] wb_dat_r,
    output logic [core_pkg::WORD_W-1:0] reg_c_value
);

    logic [core_pkg::WORD_W-1:0] reg_a;
    logic [core_pkg::WORD_W-1:0] reg_b;
    logic [core_pkg::WORD_W-1:0] reg_c;
    logic [core_pkg::MAG_W-1:0]  mag_a;
    logic [core_pkg::MAG_W-1:0]  mag_b;
    logic                        sign_a;
    logic                        sign_b;
    logic [core_pkg::WORD_W-1:0] sum;

    assign mag_a  = reg_a[core_pkg::MAG_W-1:0];
    assign mag_b  = reg_b[core_pkg::MAG_W-1:0];
    assign sign_a = reg_a[core_pkg::WORD_W-1];
    // subtract is add with b negated
    assign sign_b = reg_b[core_pkg::WORD_W-1] ^ (alu_op == core_pkg::ALU_SUB);

    always_comb begin
        if (sign_a == sign_b) begin
            sum = {sign_a, mag_a + mag_b};  // carry dropped
        end else if (mag_a > mag_b) begin
            sum = {sign_a, mag_a - mag_b};
        end else if (mag_b > mag_a) begin
            sum = {sign_b, mag_b - mag_a};
        end else begin
            sum = '0;  // equal magnitudes give plus zero
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_a <= '0;
            reg_b <= '0;
            reg_c <= '0;
        end else begin
            case (alu_op)
                core_pkg::ALU_ARR_C:  reg_c <= pnl_arr_reg_c_value;
                core_pkg::ALU_LOAD_A: reg_a <= wb_dat_r;
                core_pkg::ALU_LOAD_B: reg_b <= wb_dat_r;
                core_pkg::ALU_LOAD_C: reg_c <= wb_dat_r;
                core_pkg::ALU_ADD,
                core_pkg::ALU_SUB:    reg_c <= sum;
                core_pkg::ALU_AND:    reg_c <= {1'b0, mag_a & mag_b};
                default: ;
            endcase
        end
    end

    assign reg_c_value = reg_c;

endmodule

// ==== hw/core_pkg.sv ====
package core_pkg;

    localparam int WORD_W    = 31;  // sign + magnitude
    localparam int MAG_W     = 30;
    localparam int ADDR_W    = 12;
    localparam int OP_W      = 6;
    localparam int OP_LSB    = 24;
    localparam int ADDR1_LSB = 12;  // second address sits in the low bits

    typedef enum logic [OP_W-1:0] {
        OP_HALT  = 6'd0,
        OP_ADD   = 6'd1,
        OP_SUB   = 6'd2,
        OP_AND   = 6'd3,
        OP_STORE = 6'd4,
        OP_JUMP  = 6'd5
    } op_code_e;

    // ST_IDLE must stay at zero, the panel shows it after reset
    typedef enum logic [2:0] {
        ST_IDLE, ST_FETCH, ST_DECODE, ST_READ_A,
        ST_READ_B, ST_EXECUTE, ST_STORE, ST_PANEL
    } pu_state_e;

    typedef enum logic [2:0] {
        ALU_NONE, ALU_ARR_C, ALU_LOAD_A, ALU_LOAD_B,
        ALU_LOAD_C, ALU_ADD, ALU_SUB, ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        ADDR_NONE, ADDR_ARR_STRT, ADDR_ARR_SEL, ADDR_LOAD_INSTR,
        ADDR_SEL_STRT, ADDR_SEL_ADDR1, ADDR_SEL_ADDR2, ADDR_JUMP
    } addr_op_e;

endpackage

// ==== hw/core_top.sv ====
`timescale 1ns/100ps

module core_top #(
    parameter int MEM_DEPTH = 4096
) (
    input  logic                          clk,
    input  logic                          arst_n,

    input  logic                          pnl_start_pulse,      // pulse
    input  logic                          pnl_clear_pu,         // pulse
    input  logic                          pnl_automatic,        // level
    input  logic                          pnl_mem_read,         // pulse
    input  logic                          pnl_mem_write,        // pulse

    input  logic                          pnl_do_arr_c,         // pulse
    input  logic [core_pkg::WORD_W-1:0]   pnl_arr_reg_c_value,  // level
    input  logic                          pnl_do_arr_strt,      // pulse
    input  logic [core_pkg::ADDR_W-1:0]   pnl_arr_strt_value,   // level
    input  logic                          pnl_do_arr_sel,       // pulse
    input  logic [core_pkg::ADDR_W-1:0]   pnl_arr_sel_value,    // level

    output logic [core_pkg::OP_W-1:0]     pnl_op_code,
    output logic [core_pkg::ADDR_W-1:0]   pnl_strt_value,
    output logic [core_pkg::ADDR_W-1:0]   pnl_sel_value,
    output logic [core_pkg::WORD_W-1:0]   pnl_reg_c_value,
    output logic [2:0]                    pnl_pu_state
);

    core_pkg::alu_op_e  alu_op;
    core_pkg::addr_op_e addr_op;

    // wishbone link, sequencer to memory
    logic                        wb_cyc;
    logic                        wb_stb;
    logic                        wb_we;
    logic                        wb_ack;
    logic [core_pkg::ADDR_W-1:0] wb_adr;    // select register
    logic [core_pkg::WORD_W-1:0] wb_dat_w;  // register C
    logic [core_pkg::WORD_W-1:0] wb_dat_r;

    pulse_unit u_pulse_unit (
        .clk             ( clk             ),
        .arst_n          ( arst_n          ),
        .pnl_start_pulse ( pnl_start_pulse ),
        .pnl_clear_pu    ( pnl_clear_pu    ),
        .pnl_automatic   ( pnl_automatic   ),
        .pnl_mem_read    ( pnl_mem_read    ),
        .pnl_mem_write   ( pnl_mem_write   ),
        .pnl_do_arr_c    ( pnl_do_arr_c    ),
        .pnl_do_arr_strt ( pnl_do_arr_strt ),
        .pnl_do_arr_sel  ( pnl_do_arr_sel  ),
        .wb_ack          ( wb_ack          ),
        .wb_dat_r        ( wb_dat_r        ),
        .wb_cyc          ( wb_cyc          ),
        .wb_stb          ( wb_stb          ),
        .wb_we           ( wb_we           ),
        .alu_op          ( alu_op          ),
        .addr_op         ( addr_op         ),
        .op_code         ( pnl_op_code     ),
        .pu_state        ( pnl_pu_state    )
    );

    address_regs u_address_regs (
        .clk                ( clk                ),
        .arst_n             ( arst_n             ),
        .addr_op            ( addr_op            ),
        .pnl_arr_strt_value ( pnl_arr_strt_value ),
        .pnl_arr_sel_value  ( pnl_arr_sel_value  ),
        .wb_dat_r           ( wb_dat_r           ),
        .strt_value         ( pnl_strt_value     ),
        .sel_value          ( wb_adr             )
    );

    arith_unit u_arith_unit (
        .clk                 ( clk                 ),
        .arst_n              ( arst_n              ),
        .alu_op              ( alu_op              ),
        .pnl_arr_reg_c_value ( pnl_arr_reg_c_value ),
        .wb_dat_r            ( wb_dat_r            ),
        .reg_c_value         ( wb_dat_w            )
    );

    memory #(
        .MEM_DEPTH ( MEM_DEPTH )
    ) u_memory (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .wb_cyc   ( wb_cyc   ),
        .wb_stb   ( wb_stb   ),
        .wb_we    ( wb_we    ),
        .wb_adr   ( wb_adr   ),
        .wb_dat_w ( wb_dat_w ),
        .wb_dat_r ( wb_dat_r ),
        .wb_ack   ( wb_ack   )
    );

    assign pnl_sel_value   = wb_adr;
    assign pnl_reg_c_value = wb_dat_w;

endmodule

// ==== hw/memory.sv ====
`timescale 1ns/100ps

module memory #(
    parameter int MEM_DEPTH = 4096
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [core_pkg::ADDR_W-1:0] wb_adr,
    input  logic [core_pkg::WORD_W-1:0] wb_dat_w,
    output logic [core_pkg::WORD_W-1:0] wb_dat_r,
    output logic                        wb_ack
);

    localparam int IDX_W = $clog2(MEM_DEPTH);

    logic [core_pkg::WORD_W-1:0] mem [MEM_DEPTH];
    logic [IDX_W-1:0]            idx;
    logic                        req;

    assign idx = wb_adr[IDX_W-1:0];        // address modulo depth
    assign req = wb_cyc && wb_stb && !wb_ack;  // first cycle of an access

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            if (wb_we) mem[idx] <= wb_dat_w;
            wb_dat_r <= mem[idx];
        end
    end

endmodule

// ==== hw/pulse_unit.sv ====
`timescale 1ns/100ps

module pulse_unit (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        pnl_start_pulse,
    input  logic                        pnl_clear_pu,
    input  logic                        pnl_automatic,
    input  logic                        pnl_mem_read,
    input  logic                        pnl_mem_write,
    input  logic                        pnl_do_arr_c,
    input  logic                        pnl_do_arr_strt,
    input  logic                        pnl_do_arr_sel,
    input  logic                        wb_ack,
    input  logic [core_pkg::WORD_W-1:0] wb_dat_r,
    output logic                        wb_cyc,
    output logic                        wb_stb,
    output logic                        wb_we,
    output core_pkg::alu_op_e           alu_op,
    output core_pkg::addr_op_e          addr_op,
    output core_pkg::op_code_e          op_code,
    output core_pkg::pu_state_e         pu_state
);

    core_pkg::pu_state_e state_q;
    core_pkg::pu_state_e state_d;
    logic run_q;       // automatic mode running
    logic pnl_we_q;    // panel access is a write
    logic go_q;
    logic arr_c_q;
    logic arr_strt_q;
    logic arr_sel_q;
    logic accept;
    logic halt_dec;
    logic access;

    // panel commands only while idle with nothing pending
    assign accept = (state_q == core_pkg::ST_IDLE) && !go_q && !pnl_clear_pu;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= core_pkg::ST_IDLE;
            run_q      <= 1'b0;
            pnl_we_q   <= 1'b0;
            go_q       <= 1'b0;
            arr_c_q    <= 1'b0;
            arr_strt_q <= 1'b0;
            arr_sel_q  <= 1'b0;
            op_code    <= core_pkg::OP_HALT;
        end else begin
            state_q    <= state_d;
            go_q       <= accept && pnl_start_pulse;
            arr_c_q    <= accept && pnl_do_arr_c;
            arr_strt_q <= accept && pnl_do_arr_strt;
            arr_sel_q  <= accept && pnl_do_arr_sel;
            if (pnl_clear_pu || halt_dec) begin
                run_q <= 1'b0;
            end else if (accept && pnl_start_pulse) begin
                run_q <= pnl_automatic;
            end
            if (accept && (pnl_mem_read || pnl_mem_write)) begin
                pnl_we_q <= pnl_mem_write;
            end
            if (state_q == core_pkg::ST_FETCH && wb_ack) begin
                op_code <= core_pkg::op_code_e'(wb_dat_r[core_pkg::OP_LSB +: core_pkg::OP_W]);
            end
        end
    end

    always_comb begin
        state_d  = state_q;
        alu_op   = core_pkg::ALU_NONE;
        addr_op  = core_pkg::ADDR_NONE;
        halt_dec = 1'b0;
        case (state_q)
            core_pkg::ST_IDLE: begin
                if (arr_c_q) alu_op = core_pkg::ALU_ARR_C;
                if (arr_strt_q) begin
                    addr_op = core_pkg::ADDR_ARR_STRT;
                end else if (arr_sel_q) begin
                    addr_op = core_pkg::ADDR_ARR_SEL;
                end else if (go_q) begin
                    addr_op = core_pkg::ADDR_SEL_STRT;  // select ready as fetch starts
                end
                if (go_q) begin
                    state_d = core_pkg::ST_FETCH;
                end else if (accept && (pnl_mem_read || pnl_mem_write)) begin
                    state_d = core_pkg::ST_PANEL;
                end
            end
            core_pkg::ST_FETCH: if (wb_ack) begin
                addr_op = core_pkg::ADDR_LOAD_INSTR;
                state_d = core_pkg::ST_DECODE;
            end
            core_pkg::ST_DECODE: begin
                case (op_code)
                    core_pkg::OP_ADD, core_pkg::OP_SUB, core_pkg::OP_AND: begin
                        addr_op = core_pkg::ADDR_SEL_ADDR1;
                        state_d = core_pkg::ST_READ_A;
                    end
                    core_pkg::OP_STORE: begin
                        addr_op = core_pkg::ADDR_SEL_ADDR1;
                        state_d = core_pkg::ST_STORE;
                    end
                    core_pkg::OP_JUMP: begin
                        addr_op = core_pkg::ADDR_JUMP;
                        state_d = run_q ? core_pkg::ST_FETCH : core_pkg::ST_IDLE;
                    end
                    default: begin  // halt and unknown codes
                        halt_dec = 1'b1;
                        state_d  = core_pkg::ST_IDLE;
                    end
                endcase
            end
            core_pkg::ST_READ_A: if (wb_ack) begin
                alu_op  = core_pkg::ALU_LOAD_A;
                addr_op = core_pkg::ADDR_SEL_ADDR2;
                state_d = core_pkg::ST_READ_B;
            end
            core_pkg::ST_READ_B: if (wb_ack) begin
                alu_op  = core_pkg::ALU_LOAD_B;
                state_d = core_pkg::ST_EXECUTE;
            end
            core_pkg::ST_EXECUTE: begin
                case (op_code)
                    core_pkg::OP_SUB: alu_op = core_pkg::ALU_SUB;
                    core_pkg::OP_AND: alu_op = core_pkg::ALU_AND;
                    default:          alu_op = core_pkg::ALU_ADD;
                endcase
                if (run_q) addr_op = core_pkg::ADDR_SEL_STRT;
                state_d = run_q ? core_pkg::ST_FETCH : core_pkg::ST_IDLE;
            end
            core_pkg::ST_STORE: if (wb_ack) begin
                if (run_q) addr_op = core_pkg::ADDR_SEL_STRT;
                state_d = run_q ? core_pkg::ST_FETCH : core_pkg::ST_IDLE;
            end
            core_pkg::ST_PANEL: if (wb_ack) begin
                if (!pnl_we_q) alu_op = core_pkg::ALU_LOAD_C;
                state_d = core_pkg::ST_IDLE;
            end
            default: state_d = core_pkg::ST_IDLE;
        endcase
        if (pnl_clear_pu) state_d = core_pkg::ST_IDLE;
    end

    assign access = (state_q == core_pkg::ST_FETCH) || (state_q == core_pkg::ST_READ_A)
                 || (state_q == core_pkg::ST_READ_B) || (state_q == core_pkg::ST_STORE)
                 || (state_q == core_pkg::ST_PANEL);

    assign wb_cyc   = access;
    assign wb_stb   = access;
    assign wb_we    = (state_q == core_pkg::ST_STORE) || (state_q == core_pkg::ST_PANEL && pnl_we_q);
    assign pu_state = state_q;

endmodule

// ==== verification/core_model.svh ====
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// model of memory and panel-visible registers
logic [core_pkg::WORD_W-1:0] mdl_mem [MEM_DEPTH];
logic [core_pkg::WORD_W-1:0] mdl_c;
logic [core_pkg::ADDR_W-1:0] mdl_strt;
logic [core_pkg::ADDR_W-1:0] mdl_sel;

// sign-magnitude add, carry out of the magnitude lost
function automatic logic [30:0] sm_add(input logic [30:0] a, input logic [30:0] b);
    if (a[30] == b[30]) return {a[30], a[29:0] + b[29:0]};
    if (a[29:0] > b[29:0]) return {a[30], a[29:0] - b[29:0]};
    if (b[29:0] > a[29:0]) return {b[30], b[29:0] - a[29:0]};
    return '0;  // plus zero
endfunction

// runs the instruction at mdl_strt, returns 1 on halt
function automatic logic model_step();
    logic [30:0] ins;
    logic [30:0] opa;
    logic [30:0] opb;
    ins = mdl_mem[mdl_strt % MEM_DEPTH];
    opa = mdl_mem[ins[23:12] % MEM_DEPTH];
    opb = mdl_mem[ins[11:0] % MEM_DEPTH];
    mdl_strt = mdl_strt + 1'b1;
    model_step = 1'b0;
    case (ins[29:24])
        core_pkg::OP_ADD:   mdl_c = sm_add(opa, opb);
        core_pkg::OP_SUB:   mdl_c = sm_add(opa, {~opb[30], opb[29:0]});
        core_pkg::OP_AND:   mdl_c = {1'b0, opa[29:0] & opb[29:0]};
        core_pkg::OP_STORE: mdl_mem[ins[23:12] % MEM_DEPTH] = mdl_c;
        core_pkg::OP_JUMP:  mdl_strt = ins[23:12];
        default:            model_step = 1'b1;  // halt and unknown codes
    endcase
endfunction

`endif

// ==== verification/core_top_tb.sv ====
`timescale 1ns/100ps

module core_top_tb;

    localparam int CLK_PERIOD = 100;
    localparam int MEM_DEPTH  = 4096;
    localparam int NUM_TESTS  = 5;
    localparam int DEP_C      = 0;
    localparam int DEP_STRT   = 1;
    localparam int DEP_SEL    = 2;
    localparam int CMD_READ   = 0;
    localparam int CMD_WRITE  = 1;
    localparam int CMD_START  = 2;
    localparam int CMD_CLEAR  = 3;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        pnl_start_pulse;
    logic        pnl_clear_pu;
    logic        pnl_automatic;
    logic        pnl_mem_read;
    logic        pnl_mem_write;
    logic        pnl_do_arr_c;
    logic        pnl_do_arr_strt;
    logic        pnl_do_arr_sel;
    logic [30:0] pnl_arr_reg_c_value;
    logic [11:0] pnl_arr_strt_value;
    logic [11:0] pnl_arr_sel_value;
    logic [5:0]  pnl_op_code;
    logic [11:0] pnl_strt_value;
    logic [11:0] pnl_sel_value;
    logic [30:0] pnl_reg_c_value;
    logic [2:0]  pnl_pu_state;

    logic [31:0] lfsr_state = 32'hb895_c271;
    int          errors = 0;
    int          err_mark = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    `include "core_model.svh"

    core_top #(
        .MEM_DEPTH ( MEM_DEPTH )
    ) UUT (
        .clk                 ( clk                 ),
        .arst_n              ( arst_n              ),
        .pnl_start_pulse     ( pnl_start_pulse     ),
        .pnl_clear_pu        ( pnl_clear_pu        ),
        .pnl_automatic       ( pnl_automatic       ),
        .pnl_mem_read        ( pnl_mem_read        ),
        .pnl_mem_write       ( pnl_mem_write       ),
        .pnl_do_arr_c        ( pnl_do_arr_c        ),
        .pnl_arr_reg_c_value ( pnl_arr_reg_c_value ),
        .pnl_do_arr_strt     ( pnl_do_arr_strt     ),
        .pnl_arr_strt_value  ( pnl_arr_strt_value  ),
        .pnl_do_arr_sel      ( pnl_do_arr_sel      ),
        .pnl_arr_sel_value   ( pnl_arr_sel_value   ),
        .pnl_op_code         ( pnl_op_code         ),
        .pnl_strt_value      ( pnl_strt_value      ),
        .pnl_sel_value       ( pnl_sel_value       ),
        .pnl_reg_c_value     ( pnl_reg_c_value     ),
        .pnl_pu_state        ( pnl_pu_state        )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // fibonacci lfsr on taps 32 22 2 1 with one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [30:0] make_instr(input logic [5:0] op, input logic [11:0] a1,
                                                input logic [11:0] a2);
        logic s;
        s = lfsr_bits(1);  // sign bit is don't care
        return {s, op, a1, a2};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
            tests_failed++;
        end
        err_mark = errors;
    endtask

    // value held through the edge that applies it
    task automatic deposit(input int target, input logic [30:0] v);
        pnl_arr_reg_c_value = v;
        pnl_arr_strt_value  = v[11:0];
        pnl_arr_sel_value   = v[11:0];
        pnl_do_arr_c        = (target == DEP_C);
        pnl_do_arr_strt     = (target == DEP_STRT);
        pnl_do_arr_sel      = (target == DEP_SEL);
        @(posedge clk);
        #1;
        {pnl_do_arr_c, pnl_do_arr_strt, pnl_do_arr_sel} = '0;
        @(posedge clk);
        #1;
        case (target)
            DEP_C:    mdl_c = v;
            DEP_STRT: mdl_strt = v[11:0];
            default:  mdl_sel = v[11:0];
        endcase
    endtask

    task automatic pulse(input int cmd);
        pnl_mem_read    = (cmd == CMD_READ);
        pnl_mem_write   = (cmd == CMD_WRITE);
        pnl_start_pulse = (cmd == CMD_START);
        pnl_clear_pu    = (cmd == CMD_CLEAR);
        @(posedge clk);
        #1;
        {pnl_mem_read, pnl_mem_write, pnl_start_pulse, pnl_clear_pu} = '0;
    endtask

    task automatic wait_idle(input string what);
        int cnt;
        cnt = 0;
        @(posedge clk);
        #1;
        while (pnl_pu_state != core_pkg::ST_IDLE && cnt < 40) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (pnl_pu_state != core_pkg::ST_IDLE) begin
            $display("sequencer did not return to idle after %s", what);
            errors++;
        end
    endtask

    task automatic mem_write(input logic [11:0] a, input logic [30:0] v);
        deposit(DEP_SEL, a);
        deposit(DEP_C, v);
        pulse(CMD_WRITE);
        wait_idle("panel write");
        mdl_mem[a % MEM_DEPTH] = v;
    endtask

    task automatic mem_read(input logic [11:0] a);
        deposit(DEP_SEL, a);
        pulse(CMD_READ);
        wait_idle("panel read");
        mdl_c = mdl_mem[a % MEM_DEPTH];
    endtask

    task automatic run_from(input logic [11:0] p, input logic auto_mode);
        logic halted;
        deposit(DEP_STRT, p);
        pnl_automatic = auto_mode;
        pulse(CMD_START);
        wait_idle("instruction run");
        pnl_automatic = 1'b0;
        do begin
            halted = model_step();
        end while (auto_mode && !halted);
    endtask

    initial begin
        #(NUM_TESTS * 2000 * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        logic [11:0] p;
        logic [11:0] q;
        logic [11:0] a1;
        logic [11:0] a2;
        logic [30:0] va;
        logic [30:0] vb;
        logic [5:0]  op;
        arst_n = 1'b0;
        {pnl_start_pulse, pnl_clear_pu, pnl_automatic, pnl_mem_read, pnl_mem_write} = '0;
        {pnl_do_arr_c, pnl_do_arr_strt, pnl_do_arr_sel} = '0;
        pnl_arr_reg_c_value = '0;
        pnl_arr_strt_value  = '0;
        pnl_arr_sel_value   = '0;
        mdl_c    = '0;
        mdl_strt = '0;
        mdl_sel  = '0;
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;

        check_value("pnl_reg_c_value", pnl_reg_c_value, 0);
        check_value("pnl_strt_value", pnl_strt_value, 0);
        check_value("pnl_sel_value", pnl_sel_value, 0);
        check_value("pnl_op_code", pnl_op_code, 0);
        check_value("pnl_pu_state", pnl_pu_state, core_pkg::ST_IDLE);
        for (int i = 0; i < 5; i++) begin
            deposit(DEP_C, lfsr_bits(31));
            check_value("pnl_reg_c_value", pnl_reg_c_value, mdl_c);
            deposit(DEP_STRT, lfsr_bits(12));
            check_value("pnl_strt_value", pnl_strt_value, mdl_strt);
            deposit(DEP_SEL, lfsr_bits(12));
            check_value("pnl_sel_value", pnl_sel_value, mdl_sel);
        end
        end_test("reset and deposits");

        for (int i = 0; i < 20; i++) begin
            a1 = lfsr_bits(12);
            va = lfsr_bits(31);
            mem_write(a1, va);
            deposit(DEP_C, '0);
            mem_read(a1);
            check_value("pnl_reg_c_value", pnl_reg_c_value, va);
        end
        end_test("panel memory write and read");

        for (int i = 0; i < 30; i++) begin
            p  = lfsr_bits(12);
            a1 = p + 12'd1 + lfsr_bits(8);  // never on top of the instruction
            a2 = p + 12'd1 + lfsr_bits(8);
            va = lfsr_bits(31);
            vb = lfsr_bits(31);
            if (lfsr_bits(3) == 0) vb[29:0] = va[29:0];  // equal magnitudes now and then
            op = 1 + lfsr_bits(2) % 3;
            mem_write(a1, va);
            mem_write(a2, vb);
            mem_write(p, make_instr(op, a1, a2));
            run_from(p, 1'b0);
            check_value("pnl_reg_c_value", pnl_reg_c_value, mdl_c);
            check_value("pnl_strt_value", pnl_strt_value, 12'(p + 12'd1));
            check_value("pnl_op_code", pnl_op_code, op);
        end
        end_test("single step add, subtract and and");

        for (int i = 0; i < 3; i++) begin
            p  = lfsr_bits(12);
            a1 = p + 12'd1 + lfsr_bits(8);
            mem_write(p, make_instr(core_pkg::OP_STORE, a1, lfsr_bits(12)));
            va = lfsr_bits(31);
            deposit(DEP_C, va);
            run_from(p, 1'b0);
            check_value("pnl_strt_value", pnl_strt_value, 12'(p + 12'd1));
            deposit(DEP_C, '0);
            mem_read(a1);
            check_value("pnl_reg_c_value", pnl_reg_c_value, va);
            p  = lfsr_bits(12);
            a1 = lfsr_bits(12);
            mem_write(p, make_instr(core_pkg::OP_JUMP, a1, lfsr_bits(12)));
            run_from(p, 1'b0);
            check_value("pnl_strt_value", pnl_strt_value, a1);
            check_value("pnl_reg_c_value", pnl_reg_c_value, mdl_c);
        end
        end_test("store and jump");

        p = lfsr_bits(12);
        for (int k = 0; k < 3; k++) begin
            a1 = p + 12'd16 + lfsr_bits(8);  // operands clear of the program
            a2 = p + 12'd16 + lfsr_bits(8);
            mem_write(a1, lfsr_bits(31));
            mem_write(a2, lfsr_bits(31));
            mem_write(p + k, make_instr(1 + lfsr_bits(2) % 3, a1, a2));
        end
        mem_write(p + 3, make_instr(core_pkg::OP_HALT, lfsr_bits(12), lfsr_bits(12)));
        run_from(p, 1'b1);
        check_value("pnl_reg_c_value", pnl_reg_c_value, mdl_c);
        check_value("pnl_strt_value", pnl_strt_value, 12'(p + 12'd4));
        check_value("pnl_op_code", pnl_op_code, core_pkg::OP_HALT);
        q = p + 12'd512;
        mem_write(q, make_instr(core_pkg::OP_JUMP, q, lfsr_bits(12)));  // tight loop
        deposit(DEP_STRT, q);
        pnl_automatic = 1'b1;
        pulse(CMD_START);
        repeat (20) @(posedge clk);
        #1;
        if (pnl_pu_state == core_pkg::ST_IDLE) begin
            $display("jump loop stopped before the clear pulse");
            errors++;
        end
        pulse(CMD_CLEAR);
        pnl_automatic = 1'b0;
        check_value("pnl_pu_state", pnl_pu_state, core_pkg::ST_IDLE);
        repeat (3) @(posedge clk);
        #1;
        check_value("pnl_pu_state", pnl_pu_state, core_pkg::ST_IDLE);
        end_test("automatic run and clear");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+verification
hw/core_pkg.sv
hw/memory.sv
hw/arith_unit.sv
hw/address_regs.sv
hw/pulse_unit.sv
hw/core_top.sv
verification/core_top_tb.sv
